//--- source/noc_pkg.sv
`default_nettype none

package noc_pkg;

  // one flit on a link
  localparam int FLIT_WIDTH = 16;

  // router port numbering, also the index into per-port arrays
  typedef enum logic [2:0] {
    EAST  = 3'd0,
    WEST  = 3'd1,
    NORTH = 3'd2,
    SOUTH = 3'd3,
    LOCAL = 3'd4
  } port_e;

  localparam int NPORTS = 5;

  // forward half of a link, credit goes back on its own wire
  typedef struct packed {
    logic                  tx;
    logic [FLIT_WIDTH-1:0] data;
  } link_t;

  // destination address inside the header flit
  localparam int HDR_X_MSB = 7;
  localparam int HDR_X_LSB = 4;
  localparam int HDR_Y_MSB = 3;
  localparam int HDR_Y_LSB = 0;

  // packet layout: header, size N, then N payload flits

endpackage : noc_pkg

`default_nettype wire

//--- source/hermes_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module hermes_buffer #(
  parameter int BUFFER_DEPTH = 4
) (
  input  logic                           clock,
  input  logic                           arst_n_i,
  input  noc_pkg::link_t                 in_i,
  output logic                           credit_o,
  input  logic                           pop_i,
  output logic [noc_pkg::FLIT_WIDTH-1:0] head_o,
  output logic                           nonempty_o
);
  import noc_pkg::*;

  localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

  logic [FLIT_WIDTH-1:0] mem_q [BUFFER_DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic [CNT_W-1:0]      count_d;
  logic                  credit_q;
  logic                  push;
  logic                  pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    // wrap at the last slot, depth need not be a power of two
    if (ptr == PTR_W'(BUFFER_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push = in_i.tx && (count_q != CNT_W'(BUFFER_DEPTH));
  assign pop  = pop_i && (count_q != '0);

  always_comb begin
    count_d = count_q;
    if (push && !pop) begin
      count_d = count_q + 1'b1;
    end else if (pop && !push) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b1;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q  <= count_d;
      // credit tracks room left after this edge
      credit_q <= (count_d != CNT_W'(BUFFER_DEPTH));
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_i.data;
    end
  end

  assign credit_o   = credit_q;
  assign head_o     = mem_q[rd_ptr_q];
  assign nonempty_o = (count_q != '0);

endmodule : hermes_buffer

`default_nettype wire

//--- source/switch_control.sv
`timescale 1ns/1ps
`default_nettype none

module switch_control #(
  parameter int ROUTER_X = 0,
  parameter int ROUTER_Y = 0
) (
  input  logic                                                 clock,
  input  logic                                                 arst_n_i,
  input  logic [noc_pkg::NPORTS-1:0][noc_pkg::FLIT_WIDTH-1:0] head_i,
  input  logic [noc_pkg::NPORTS-1:0]                           nonempty_i,
  input  logic [noc_pkg::NPORTS-1:0]                           pop_i,
  output noc_pkg::port_e [noc_pkg::NPORTS-1:0]                 sel_o,
  output logic [noc_pkg::NPORTS-1:0]                           busy_o
);
  import noc_pkg::*;

  typedef enum logic [1:0] {
    SC_IDLE,
    SC_ROUTE,
    SC_WAIT
  } sc_state_e;

  localparam int XW = HDR_X_MSB - HDR_X_LSB + 1;
  localparam int YW = HDR_Y_MSB - HDR_Y_LSB + 1;
  localparam logic [XW-1:0] MY_X = XW'(ROUTER_X);
  localparam logic [YW-1:0] MY_Y = YW'(ROUTER_Y);

  sc_state_e state_q;
  port_e     cur_in_q;
  port_e     tgt_q;
  // last input served, start point of the round-robin scan
  port_e     rr_q;
  port_e     next_in;
  logic      next_vld;
  port_e     route_out;

  logic  [NPORTS-1:0]                 bound_q;
  logic  [NPORTS-1:0]                 sized_q;
  port_e [NPORTS-1:0]                 owner_q;
  logic  [NPORTS-1:0][FLIT_WIDTH-1:0] left_q;
  port_e [NPORTS-1:0]                 sel_q;
  logic  [NPORTS-1:0]                 busy_q;
  logic  [NPORTS-1:0]                 done;

  // next input holding an unrouted header
  always_comb begin
    int idx;
    next_vld = 1'b0;
    next_in  = rr_q;
    for (int k = 1; k <= NPORTS; k++) begin
      idx = (int'(rr_q) + k) % NPORTS;
      if (!next_vld && nonempty_i[idx] && !bound_q[idx]) begin
        next_vld = 1'b1;
        next_in  = port_e'(idx);
      end
    end
  end

  // xy order, x first
  always_comb begin
    logic [XW-1:0] dx;
    logic [YW-1:0] dy;
    dx = head_i[cur_in_q][HDR_X_MSB:HDR_X_LSB];
    dy = head_i[cur_in_q][HDR_Y_MSB:HDR_Y_LSB];
    if (dx > MY_X) begin
      route_out = EAST;
    end else if (dx < MY_X) begin
      route_out = WEST;
    end else if (dy > MY_Y) begin
      route_out = NORTH;
    end else if (dy < MY_Y) begin
      route_out = SOUTH;
    end else begin
      route_out = LOCAL;
    end
  end

  // last flit leaves, or a size flit of zero with nothing behind it
  always_comb begin
    for (int i = 0; i < NPORTS; i++) begin
      if (sized_q[i]) begin
        done[i] = pop_i[i] && (left_q[i] == FLIT_WIDTH'(1));
      end else begin
        done[i] = pop_i[i] && (left_q[i] == FLIT_WIDTH'(1)) && (head_i[i] == '0);
      end
    end
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= SC_IDLE;
      cur_in_q <= EAST;
      tgt_q    <= EAST;
      rr_q     <= LOCAL;
      bound_q  <= '0;
      sized_q  <= '0;
      left_q   <= '0;
      busy_q   <= '0;
      for (int i = 0; i < NPORTS; i++) begin
        owner_q[i] <= EAST;
        sel_q[i]   <= EAST;
      end
    end else begin
      // per input flit count, left_q starts at 2 for header and size
      for (int i = 0; i < NPORTS; i++) begin
        if (pop_i[i]) begin
          if (sized_q[i]) begin
            left_q[i] <= left_q[i] - 1'b1;
          end else if (left_q[i] == FLIT_WIDTH'(2)) begin
            left_q[i] <= FLIT_WIDTH'(1);
          end else begin
            left_q[i]  <= head_i[i];
            sized_q[i] <= 1'b1;
          end
        end
        if (done[i]) begin
          bound_q[i]         <= 1'b0;
          busy_q[owner_q[i]] <= 1'b0;
        end
      end

      case (state_q)
        SC_IDLE: begin
          if (next_vld) begin
            cur_in_q <= next_in;
            state_q  <= SC_ROUTE;
          end
        end
        SC_ROUTE: begin
          tgt_q   <= route_out;
          state_q <= SC_WAIT;
        end
        SC_WAIT: begin
          if (!busy_q[tgt_q]) begin
            busy_q[tgt_q]     <= 1'b1;
            sel_q[tgt_q]      <= cur_in_q;
            bound_q[cur_in_q] <= 1'b1;
            owner_q[cur_in_q] <= tgt_q;
            sized_q[cur_in_q] <= 1'b0;
            left_q[cur_in_q]  <= FLIT_WIDTH'(2);
            rr_q              <= cur_in_q;
            state_q           <= SC_IDLE;
          end
        end
        default: begin
          state_q <= SC_IDLE;
        end
      endcase
    end
  end

  assign sel_o  = sel_q;
  assign busy_o = busy_q;

endmodule : switch_control

`default_nettype wire

//--- source/crossbar.sv
`timescale 1ns/1ps
`default_nettype none

module crossbar (
  input  logic [noc_pkg::NPORTS-1:0]                           busy_i,
  input  noc_pkg::port_e [noc_pkg::NPORTS-1:0]                 sel_i,
  input  logic [noc_pkg::NPORTS-1:0][noc_pkg::FLIT_WIDTH-1:0] head_i,
  input  logic [noc_pkg::NPORTS-1:0]                           nonempty_i,
  input  logic [noc_pkg::NPORTS-1:0]                           credit_i,
  output noc_pkg::link_t [noc_pkg::NPORTS-1:0]                 out_o,
  output logic [noc_pkg::NPORTS-1:0]                           pop_o
);
  import noc_pkg::*;

  // a flit moves on output o in this cycle
  logic [NPORTS-1:0] fire;

  always_comb begin
    pop_o = '0;
    for (int o = 0; o < NPORTS; o++) begin
      fire[o] = busy_i[o] && nonempty_i[sel_i[o]] && credit_i[o];

      out_o[o].tx = fire[o];
      if (busy_i[o]) begin
        out_o[o].data = head_i[sel_i[o]];
      end else begin
        out_o[o].data = '0;
      end

      // an input drives at most one output, so one pop per input
      if (fire[o]) begin
        pop_o[sel_i[o]] = 1'b1;
      end
    end
  end

endmodule : crossbar

`default_nettype wire

//--- source/router.sv
`timescale 1ns/1ps
`default_nettype none

module router #(
  parameter int ROUTER_X     = 0,
  parameter int ROUTER_Y     = 0,
  parameter int BUFFER_DEPTH = 4
) (
  input  logic                                 clock,
  input  logic                                 arst_n_i,
  input  noc_pkg::link_t [noc_pkg::NPORTS-1:0] in_i,
  output logic [noc_pkg::NPORTS-1:0]           credit_o,
  output noc_pkg::link_t [noc_pkg::NPORTS-1:0] out_o,
  input  logic [noc_pkg::NPORTS-1:0]           credit_i
);
  import noc_pkg::*;

  logic  [NPORTS-1:0][FLIT_WIDTH-1:0] head;
  logic  [NPORTS-1:0]                 nonempty;
  logic  [NPORTS-1:0]                 pop;
  port_e [NPORTS-1:0]                 sel;
  logic  [NPORTS-1:0]                 busy;

  // one input FIFO per port
  for (genvar p = 0; p < NPORTS; p++) begin : gen_buf
    hermes_buffer #(
      .BUFFER_DEPTH(BUFFER_DEPTH)
    ) u_buf (
      .clock     (clock),
      .arst_n_i  (arst_n_i),
      .in_i      (in_i[p]),
      .credit_o  (credit_o[p]),
      .pop_i     (pop[p]),
      .head_o    (head[p]),
      .nonempty_o(nonempty[p])
    );
  end

  switch_control #(
    .ROUTER_X(ROUTER_X),
    .ROUTER_Y(ROUTER_Y)
  ) u_ctrl (
    .clock     (clock),
    .arst_n_i  (arst_n_i),
    .head_i    (head),
    .nonempty_i(nonempty),
    .pop_i     (pop),
    .sel_o     (sel),
    .busy_o    (busy)
  );

  crossbar u_xbar (
    .busy_i    (busy),
    .sel_i     (sel),
    .head_i    (head),
    .nonempty_i(nonempty),
    .credit_i  (credit_i),
    .out_o     (out_o),
    .pop_o     (pop)
  );

endmodule : router

`default_nettype wire

//--- source/noc_mesh.sv
`timescale 1ns/1ps
`default_nettype none

module noc_mesh #(
  parameter int NOC_DIM_X    = 2,
  parameter int NOC_DIM_Y    = 2,
  parameter int BUFFER_DEPTH = 4
) (
  input  logic                                   clock,
  input  logic                                   arst_n_i,
  input  noc_pkg::link_t [NOC_DIM_X*NOC_DIM_Y-1:0] local_in_i,
  output logic [NOC_DIM_X*NOC_DIM_Y-1:0]           local_credit_o,
  output noc_pkg::link_t [NOC_DIM_X*NOC_DIM_Y-1:0] local_out_o,
  input  logic [NOC_DIM_X*NOC_DIM_Y-1:0]           local_credit_i
);
  import noc_pkg::*;

  localparam int NODES = NOC_DIM_X * NOC_DIM_Y;

  // per node, per port router pins
  link_t [NPORTS-1:0] r_in      [NODES];
  logic  [NPORTS-1:0] r_credit_o [NODES];
  link_t [NPORTS-1:0] r_out     [NODES];
  logic  [NPORTS-1:0] r_credit_i [NODES];

  for (genvar x = 0; x < NOC_DIM_X; x++) begin : gen_x
    for (genvar y = 0; y < NOC_DIM_Y; y++) begin : gen_y
      localparam int N = y * NOC_DIM_X + x;

      router #(
        .ROUTER_X    (x),
        .ROUTER_Y    (y),
        .BUFFER_DEPTH(BUFFER_DEPTH)
      ) u_router (
        .clock   (clock),
        .arst_n_i(arst_n_i),
        .in_i    (r_in[N]),
        .credit_o(r_credit_o[N]),
        .out_o   (r_out[N]),
        .credit_i(r_credit_i[N])
      );

      // local port straight to the top
      assign r_in[N][LOCAL]       = local_in_i[N];
      assign local_credit_o[N]    = r_credit_o[N][LOCAL];
      assign local_out_o[N]       = r_out[N][LOCAL];
      assign r_credit_i[N][LOCAL] = local_credit_i[N];

      if (x == 0) begin : gen_west_gnd
        assign r_in[N][WEST]       = '0;
        assign r_credit_i[N][WEST] = 1'b0;
      end else begin : gen_west_link
        // both directions of the link to the left neighbor
        assign r_in[N][WEST]         = r_out[N-1][EAST];
        assign r_credit_i[N][WEST]   = r_credit_o[N-1][EAST];
        assign r_in[N-1][EAST]       = r_out[N][WEST];
        assign r_credit_i[N-1][EAST] = r_credit_o[N][WEST];
      end

      if (x == NOC_DIM_X - 1) begin : gen_east_gnd
        assign r_in[N][EAST]       = '0;
        assign r_credit_i[N][EAST] = 1'b0;
      end

      if (y == 0) begin : gen_south_gnd
        assign r_in[N][SOUTH]       = '0;
        assign r_credit_i[N][SOUTH] = 1'b0;
      end else begin : gen_south_link
        // node below sits one row back
        assign r_in[N][SOUTH]                 = r_out[N-NOC_DIM_X][NORTH];
        assign r_credit_i[N][SOUTH]           = r_credit_o[N-NOC_DIM_X][NORTH];
        assign r_in[N-NOC_DIM_X][NORTH]       = r_out[N][SOUTH];
        assign r_credit_i[N-NOC_DIM_X][NORTH] = r_credit_o[N][SOUTH];
      end

      if (y == NOC_DIM_Y - 1) begin : gen_north_gnd
        assign r_in[N][NORTH]       = '0;
        assign r_credit_i[N][NORTH] = 1'b0;
      end
    end
  end

endmodule : noc_mesh

`default_nettype wire

//--- testbench/tb_noc_mesh.sv
`timescale 1ns/1ps
`default_nettype none

module tb_noc_mesh;
  import noc_pkg::*;

  localparam int NX           = 2;
  localparam int NY           = 2;
  localparam int NODES        = NX * NY;
  localparam int BUFFER_DEPTH = 4;
  // single, all pairs, contention, back-pressure, back to back
  localparam int NUM_PACKETS  = 1 + NODES * NODES + 2 + 1 + 2;
  localparam int CYCLE_LIMIT  = 200 * NUM_PACKETS + 500;

  logic                   clock;
  logic                   arst_n_i;
  link_t [NODES-1:0]      local_in_i;
  logic  [NODES-1:0]      local_credit_o;
  link_t [NODES-1:0]      local_out_o;
  logic  [NODES-1:0]      local_credit_i;

  // expected packets per slot, received flits per local port
  logic [FLIT_WIDTH-1:0] pkt_q [2][$];
  logic [FLIT_WIDTH-1:0] rx_q [NODES][$];

  logic [31:0] rng_state = 32'h47ee_dac5;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  noc_mesh #(
    .NOC_DIM_X   (NX),
    .NOC_DIM_Y   (NY),
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) u_dut (
    .clock         (clock),
    .arst_n_i      (arst_n_i),
    .local_in_i    (local_in_i),
    .local_credit_o(local_credit_o),
    .local_out_o   (local_out_o),
    .local_credit_i(local_credit_i)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("Test failures found");
    $finish;
  end

  // flits move on the next rising edge, sample once the falling edge drives settle
  initial begin
    forever begin
      @(negedge clock);
      #1;
      for (int k = 0; k < NODES; k++) begin
        if (local_out_o[k].tx) begin
          if (local_credit_i[k]) begin
            rx_q[k].push_back(local_out_o[k].data);
          end else begin
            errors++;
            $display("local port %0d offered a flit while its credit was low", k);
          end
        end
      end
    end
  end

  function automatic logic [15:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // header carries the source in bits 11:8, only bits 7:0 route
  task automatic make_packet(input int slot, input int src, input int dst, input int n);
    logic [FLIT_WIDTH-1:0] hdr;
    hdr = {4'h0, 4'(src), 4'(dst % NX), 4'(dst / NX)};
    pkt_q[slot].delete();
    pkt_q[slot].push_back(hdr);
    pkt_q[slot].push_back(16'(n));
    for (int i = 0; i < n; i++) begin
      pkt_q[slot].push_back(next_rand());
    end
  endtask

  task automatic send_packet(input int slot, input int src);
    int i;
    i = 0;
    while (i < pkt_q[slot].size()) begin
      @(negedge clock);
      if (local_credit_o[src]) begin
        local_in_i[src].tx   = 1'b1;
        local_in_i[src].data = pkt_q[slot][i];
        i++;
      end else begin
        local_in_i[src] = '0;
      end
    end
    @(negedge clock);
    local_in_i[src] = '0;
  endtask

  task automatic wait_rx(input int port, input int count);
    while (rx_q[port].size() < count) begin
      @(negedge clock);
    end
  endtask

  task automatic expect_packet(input int slot, input int port);
    logic [FLIT_WIDTH-1:0] got;
    int                    n;
    n = pkt_q[slot].size();
    wait_rx(port, n);
    for (int i = 0; i < n; i++) begin
      got = rx_q[port].pop_front();
      check_value($sformatf("local_out_o[%0d].data flit %0d", port, i),
                  32'(got), 32'(pkt_q[slot][i]));
    end
  endtask

  // arrival order is open, the source field of the first header decides
  task automatic expect_either_order(input int slot_a, input int slot_b, input int port);
    logic [FLIT_WIDTH-1:0] first;
    wait_rx(port, 1);
    first = rx_q[port][0];
    if (first[11:8] == pkt_q[slot_a][0][11:8]) begin
      expect_packet(slot_a, port);
      expect_packet(slot_b, port);
    end else begin
      expect_packet(slot_b, port);
      expect_packet(slot_a, port);
    end
  endtask

  // nothing extra on any port, duplicates included
  task automatic check_no_stray_flits();
    repeat (10) @(negedge clock);
    for (int k = 0; k < NODES; k++) begin
      check_value($sformatf("stray flits on local_out_o[%0d]", k), 32'(rx_q[k].size()), 32'd0);
      rx_q[k].delete();
    end
  endtask

  task automatic test_reset_state();
    for (int k = 0; k < NODES; k++) begin
      check_value($sformatf("local_out_o[%0d].tx", k), 32'(local_out_o[k].tx), 32'd0);
      check_value($sformatf("local_credit_o[%0d]", k), 32'(local_credit_o[k]), 32'd1);
    end
  endtask

  task automatic test_single_packet();
    make_packet(0, 0, 3, 4);
    fork
      send_packet(0, 0);
      expect_packet(0, 3);
    join
    check_no_stray_flits();
  endtask

  task automatic test_all_pairs();
    for (int s = 0; s < NODES; s++) begin
      for (int d = 0; d < NODES; d++) begin
        // sizes 0 to 4, zero payload included
        make_packet(0, s, d, (s * NODES + d) % 5);
        fork
          send_packet(0, s);
          expect_packet(0, d);
        join
        check_no_stray_flits();
      end
    end
  endtask

  task automatic test_contention();
    make_packet(0, 0, 1, 3);
    make_packet(1, 3, 1, 5);
    fork
      send_packet(0, 0);
      send_packet(1, 3);
      expect_either_order(0, 1, 1);
    join
    check_no_stray_flits();
  endtask

  task automatic test_backpressure();
    make_packet(0, 0, 3, 12);
    @(negedge clock);
    local_credit_i[3] = 1'b0;
    fork
      send_packet(0, 0);
      begin
        repeat (40) @(negedge clock);
        // three buffers on the path hold 3 * BUFFER_DEPTH flits, fewer than the packet
        check_value("local_credit_o[0] under back-pressure",
                    32'(local_credit_o[0]), 32'd0);
        local_credit_i[3] = 1'b1;
        expect_packet(0, 3);
      end
    join
    check_no_stray_flits();
  endtask

  task automatic test_back_to_back();
    make_packet(0, 2, 1, 6);
    make_packet(1, 2, 1, 2);
    fork
      begin
        send_packet(0, 2);
        send_packet(1, 2);
      end
      begin
        expect_packet(0, 1);
        expect_packet(1, 1);
      end
    join
    check_no_stray_flits();
  endtask

  initial begin
    arst_n_i       = 1'b0;
    local_in_i     = '0;
    local_credit_i = '1;
    repeat (8) @(posedge clock);
    @(negedge clock);
    arst_n_i = 1'b1;
    @(negedge clock);

    test_reset_state();
    test_single_packet();
    test_all_pairs();
    test_contention();
    test_backpressure();
    test_back_to_back();

    $display("tb_noc_mesh finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tb_noc_mesh

`default_nettype wire

//--- filelist.f
source/noc_pkg.sv
source/hermes_buffer.sv
source/switch_control.sv
source/crossbar.sv
source/router.sv
source/noc_mesh.sv
testbench/tb_noc_mesh.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the NoC mesh testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_noc_mesh -f filelist.f -o sim_noc_mesh

./obj_dir/sim_noc_mesh | tee sim.log

if grep -qFx "All tests passed!" sim.log; then
  echo "simulation PASSED"
  exit 0
else
  echo "simulation FAILED"
  exit 1
fi
